//--- hw/fp_mul_pkg.sv
`default_nettype none

package fp_mul_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // binary32 format

  localparam int FLEN       = 32;
  localparam int EXPO_WIDTH = 8;
  localparam int FRAC_WIDTH = 23;
  localparam int BIAS       = 127;

  // bit positions inside fflags (NV DZ OF UF NX, msb first)
  localparam int FLAG_NV = 4;
  localparam int FLAG_OF = 2;
  localparam int FLAG_UF = 1;
  localparam int FLAG_NX = 0;

  typedef logic [FLEN-1:0]           fp_word_t;
  // two extra bits for overflow and for sums below the bias
  typedef logic [EXPO_WIDTH+1:0]     fp_expo_t;
  typedef logic [FRAC_WIDTH:0]       fp_mant_t;
  typedef logic [2*FRAC_WIDTH+1:0]   fp_prod_t;
  typedef logic [4:0]                fp_flags_t;

  typedef enum logic [2:0] {
    RNE = 3'd0,
    RTZ = 3'd1,
    RDN = 3'd2,
    RUP = 3'd3,
    RMM = 3'd4
  } rounding_mode_t;

  localparam fp_word_t CANONICAL_NAN = 32'h7fc00000;

  ////////////////////////////////////////////////////////////////////////////
  // bundles

  typedef struct packed {
    fp_word_t       rs1;
    fp_word_t       rs2;
    rounding_mode_t rm;
  } fp_mul_req_t;

  typedef struct packed {
    logic result_nan;
    logic result_inf;
    logic result_zero;
    logic invalid;
  } fp_special_t;

  // travels next to the mantissa pipeline
  typedef struct packed {
    logic           sign;
    fp_expo_t       expo;
    fp_special_t    special;
    rounding_mode_t rm;
  } fp_mul_stage_t;

  typedef struct packed {
    fp_word_t  rd;
    fp_flags_t fflags;
  } fp_mul_wb_t;

endpackage

`default_nettype wire

//--- hw/fp_operand_classify.sv
`default_nettype none
`timescale 1ns/10ps

module fp_operand_classify (
  input  fp_mul_pkg::fp_mul_req_t   req,
  output fp_mul_pkg::fp_mant_t      mant_a,
  output fp_mul_pkg::fp_mant_t      mant_b,
  output fp_mul_pkg::fp_mul_stage_t stage
);

  logic [fp_mul_pkg::EXPO_WIDTH-1:0] exp_a;
  logic [fp_mul_pkg::EXPO_WIDTH-1:0] exp_b;
  logic [fp_mul_pkg::FRAC_WIDTH-1:0] frac_a;
  logic [fp_mul_pkg::FRAC_WIDTH-1:0] frac_b;
  logic a_zero, a_inf, a_nan, a_snan;
  logic b_zero, b_inf, b_nan, b_snan;
  logic invalid, result_nan, result_inf;

  assign exp_a  = req.rs1[fp_mul_pkg::FLEN-2 -: fp_mul_pkg::EXPO_WIDTH];
  assign exp_b  = req.rs2[fp_mul_pkg::FLEN-2 -: fp_mul_pkg::EXPO_WIDTH];
  assign frac_a = req.rs1[fp_mul_pkg::FRAC_WIDTH-1:0];
  assign frac_b = req.rs2[fp_mul_pkg::FRAC_WIDTH-1:0];

  // exponent field of zero counts as zero, subnormals included
  assign a_zero = (exp_a == '0);
  assign b_zero = (exp_b == '0);
  assign a_inf  = (&exp_a) & (frac_a == '0);
  assign b_inf  = (&exp_b) & (frac_b == '0);
  assign a_nan  = (&exp_a) & (frac_a != '0);
  assign b_nan  = (&exp_b) & (frac_b != '0);
  // quiet bit clear marks a signaling NaN
  assign a_snan = a_nan & ~frac_a[fp_mul_pkg::FRAC_WIDTH-1];
  assign b_snan = b_nan & ~frac_b[fp_mul_pkg::FRAC_WIDTH-1];

  assign mant_a = a_zero ? '0 : {1'b1, frac_a};
  assign mant_b = b_zero ? '0 : {1'b1, frac_b};

  assign invalid    = a_snan | b_snan | (a_inf & b_zero) | (a_zero & b_inf);
  assign result_nan = invalid | a_nan | b_nan;
  assign result_inf = (a_inf | b_inf) & ~result_nan;

  always_comb begin
    stage.sign = req.rs1[fp_mul_pkg::FLEN-1] ^ req.rs2[fp_mul_pkg::FLEN-1];
    // may go negative or past 254, the rounding stage sorts that out
    stage.expo = fp_mul_pkg::fp_expo_t'(exp_a) + fp_mul_pkg::fp_expo_t'(exp_b)
               - fp_mul_pkg::fp_expo_t'(fp_mul_pkg::BIAS);
    stage.special.result_nan  = result_nan;
    stage.special.result_inf  = result_inf;
    stage.special.result_zero = (a_zero | b_zero) & ~result_nan & ~result_inf;
    stage.special.invalid     = invalid;
    stage.rm = req.rm;
  end

endmodule

`default_nettype wire

//--- hw/fp_mant_multiplier.sv
`default_nettype none
`timescale 1ns/10ps

module fp_mant_multiplier (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 advance1,
  input  logic                 advance2,
  input  fp_mul_pkg::fp_mant_t mant_a,
  input  fp_mul_pkg::fp_mant_t mant_b,
  output fp_mul_pkg::fp_prod_t product
);

  fp_mul_pkg::fp_mant_t op_a;
  fp_mul_pkg::fp_mant_t op_b;

  ////////////////////////////////////////////////////////////////////////////
  // stage 1 holds the operands

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      op_a <= '0;
      op_b <= '0;
    end else if (advance1) begin
      op_a <= mant_a;
      op_b <= mant_b;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage 2 holds the full 48-bit product

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      product <= '0;
    end else if (advance2) begin
      product <= fp_mul_pkg::fp_prod_t'(op_a) * fp_mul_pkg::fp_prod_t'(op_b);
    end
  end

endmodule

`default_nettype wire

//--- hw/fp_exponent_path.sv
`default_nettype none
`timescale 1ns/10ps

module fp_exponent_path #(
  parameter int ID_WIDTH = 4
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      advance1,
  input  logic                      advance2,
  input  fp_mul_pkg::fp_mul_stage_t stage_in,
  input  logic [ID_WIDTH-1:0]       id_in,
  output fp_mul_pkg::fp_mul_stage_t stage_out,
  output logic [ID_WIDTH-1:0]       id_out
);

  fp_mul_pkg::fp_mul_stage_t stage1;
  logic [ID_WIDTH-1:0]       id1;

  // stage 1, in step with the operand registers of the multiplier
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stage1 <= '0;
      id1    <= '0;
    end else if (advance1) begin
      stage1 <= stage_in;
      id1    <= id_in;
    end
  end

  // stage 2, in step with the product register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stage_out <= '0;
      id_out    <= '0;
    end else if (advance2) begin
      stage_out <= stage1;
      id_out    <= id1;
    end
  end

endmodule

`default_nettype wire

//--- hw/fp_mul_normalize_round.sv
`default_nettype none
`timescale 1ns/10ps

module fp_mul_normalize_round #(
  parameter int ID_WIDTH = 4
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      advance3,
  input  fp_mul_pkg::fp_prod_t      product,
  input  fp_mul_pkg::fp_mul_stage_t stage,
  input  logic [ID_WIDTH-1:0]       id_in,
  output fp_mul_pkg::fp_mul_wb_t    wb,
  output logic [ID_WIDTH-1:0]       wb_id
);

  localparam int FW = fp_mul_pkg::FRAC_WIDTH;

  logic                 top;
  fp_mul_pkg::fp_prod_t shifted;
  fp_mul_pkg::fp_mant_t mant;
  logic                 guard;
  logic                 sticky;
  logic                 round_up;
  logic                 to_inf;
  logic [FW+1:0]        rounded;
  logic [FW-1:0]        frac_out;
  fp_mul_pkg::fp_expo_t expo_norm;
  fp_mul_pkg::fp_expo_t expo_final;
  fp_mul_pkg::fp_mul_wb_t wb_next;

  ////////////////////////////////////////////////////////////////////////////
  // normalize, product is in [1,4)

  assign top       = product[2*FW+1];
  assign shifted   = top ? product : (product << 1);
  assign mant      = shifted[2*FW+1 -: FW+1];
  assign guard     = shifted[FW];
  assign sticky    = |shifted[FW-1:0];
  assign expo_norm = stage.expo + fp_mul_pkg::fp_expo_t'(top);

  ////////////////////////////////////////////////////////////////////////////
  // round

  always_comb begin
    case (stage.rm)
      fp_mul_pkg::RNE: round_up = guard & (sticky | mant[0]);
      fp_mul_pkg::RTZ: round_up = 1'b0;
      fp_mul_pkg::RDN: round_up = stage.sign & (guard | sticky);
      fp_mul_pkg::RUP: round_up = ~stage.sign & (guard | sticky);
      fp_mul_pkg::RMM: round_up = guard;
      default:         round_up = 1'b0;
    endcase
  end

  // overflow goes to infinity unless the mode rounds toward zero for this sign
  always_comb begin
    case (stage.rm)
      fp_mul_pkg::RTZ: to_inf = 1'b0;
      fp_mul_pkg::RDN: to_inf = stage.sign;
      fp_mul_pkg::RUP: to_inf = ~stage.sign;
      default:         to_inf = 1'b1;
    endcase
  end

  assign rounded = {1'b0, mant} + (FW+2)'(round_up);
  // carry out means 1.111.. rounded up to 2.0
  assign frac_out   = rounded[FW+1] ? rounded[FW:1] : rounded[FW-1:0];
  assign expo_final = expo_norm + fp_mul_pkg::fp_expo_t'(rounded[FW+1]);

  ////////////////////////////////////////////////////////////////////////////
  // result select, specials first

  always_comb begin
    wb_next.fflags = '0;
    if (stage.special.result_nan) begin
      wb_next.rd = fp_mul_pkg::CANONICAL_NAN;
      wb_next.fflags[fp_mul_pkg::FLAG_NV] = stage.special.invalid;
    end else if (stage.special.result_inf) begin
      wb_next.rd = {stage.sign, 8'hff, {FW{1'b0}}};
    end else if (stage.special.result_zero) begin
      wb_next.rd = {stage.sign, 31'd0};
    end else if ($signed(expo_norm) < 1) begin
      // subnormal range is flushed
      wb_next.rd = {stage.sign, 31'd0};
      wb_next.fflags[fp_mul_pkg::FLAG_UF] = 1'b1;
      wb_next.fflags[fp_mul_pkg::FLAG_NX] = 1'b1;
    end else if ($signed(expo_final) >= 255) begin
      wb_next.rd = to_inf ? {stage.sign, 8'hff, {FW{1'b0}}}
                          : {stage.sign, 8'hfe, {FW{1'b1}}};
      wb_next.fflags[fp_mul_pkg::FLAG_OF] = 1'b1;
      wb_next.fflags[fp_mul_pkg::FLAG_NX] = 1'b1;
    end else begin
      wb_next.rd = {stage.sign, expo_final[fp_mul_pkg::EXPO_WIDTH-1:0], frac_out};
      wb_next.fflags[fp_mul_pkg::FLAG_NX] = guard | sticky;
    end
  end

  // writeback register, held while ack is low
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb    <= '0;
      wb_id <= '0;
    end else if (advance3) begin
      wb    <= wb_next;
      wb_id <= id_in;
    end
  end

endmodule

`default_nettype wire

//--- hw/fp_mul_pipeline_ctrl.sv
`default_nettype none
`timescale 1ns/10ps

module fp_mul_pipeline_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic new_request,
  input  logic ack,
  output logic ready,
  output logic advance1,
  output logic advance2,
  output logic advance3,
  output logic done
);

  logic valid1;
  logic valid2;

  // a stage moves when it is empty or the stage ahead moves
  assign advance3 = ack | ~done;
  assign advance2 = ~valid2 | advance3;
  assign advance1 = ~valid1 | advance2;
  assign ready    = advance1;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid1 <= 1'b0;
      valid2 <= 1'b0;
      done   <= 1'b0;
    end else begin
      if (advance1) begin
        valid1 <= new_request;
      end
      if (advance2) begin
        valid2 <= valid1;
      end
      // stage 3 valid is the writeback done
      if (advance3) begin
        done <= valid2;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/fp_mul_unit.sv
`default_nettype none
`timescale 1ns/10ps

module fp_mul_unit #(
  parameter int ID_WIDTH = 4
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    new_request,
  input  fp_mul_pkg::fp_mul_req_t req,
  input  logic [ID_WIDTH-1:0]     id,
  output logic                    ready,
  output logic                    done,
  output fp_mul_pkg::fp_mul_wb_t  wb,
  output logic [ID_WIDTH-1:0]     wb_id,
  input  logic                    ack
);

  logic                      advance1;
  logic                      advance2;
  logic                      advance3;
  fp_mul_pkg::fp_mant_t      mant_a;
  fp_mul_pkg::fp_mant_t      mant_b;
  fp_mul_pkg::fp_mul_stage_t stage0;
  fp_mul_pkg::fp_mul_stage_t stage2;
  fp_mul_pkg::fp_prod_t      product;
  logic [ID_WIDTH-1:0]       id2;

  fp_mul_pipeline_ctrl u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .new_request (new_request),
    .ack         (ack),
    .ready       (ready),
    .advance1    (advance1),
    .advance2    (advance2),
    .advance3    (advance3),
    .done        (done)
  );

  fp_operand_classify u_classify (
    .req    (req),
    .mant_a (mant_a),
    .mant_b (mant_b),
    .stage  (stage0)
  );

  fp_mant_multiplier u_mant_mul (
    .clk      (clk),
    .rst_n    (rst_n),
    .advance1 (advance1),
    .advance2 (advance2),
    .mant_a   (mant_a),
    .mant_b   (mant_b),
    .product  (product)
  );

  fp_exponent_path #(.ID_WIDTH(ID_WIDTH)) u_expo_path (
    .clk       (clk),
    .rst_n     (rst_n),
    .advance1  (advance1),
    .advance2  (advance2),
    .stage_in  (stage0),
    .id_in     (id),
    .stage_out (stage2),
    .id_out    (id2)
  );

  fp_mul_normalize_round #(.ID_WIDTH(ID_WIDTH)) u_norm_round (
    .clk      (clk),
    .rst_n    (rst_n),
    .advance3 (advance3),
    .product  (product),
    .stage    (stage2),
    .id_in    (id2),
    .wb       (wb),
    .wb_id    (wb_id)
  );

endmodule

`default_nettype wire

//--- testbench/fp_mul_tb.sv
`default_nettype none
`timescale 1ns/10ps

module fp_mul_tb;

  localparam int ID_WIDTH         = 4;
  localparam int NUM_RANDOM       = 400;
  localparam int NUM_BACKPRESSURE = 40;
  // about three cycles per operation with a toggling ack, doubled for margin
  localparam int MAX_CYCLES       = 2 * 3 * (NUM_RANDOM + 100);
  localparam logic [31:0] SEED    = 32'h47e2;

  logic                   clk         = 1'b0;
  logic                   rst_n       = 1'b0;
  logic                   new_request = 1'b0;
  fp_mul_pkg::fp_mul_req_t req        = '0;
  logic [ID_WIDTH-1:0]    id          = '0;
  logic                   ack         = 1'b0;
  logic                   ready;
  logic                   done;
  fp_mul_pkg::fp_mul_wb_t wb;
  logic [ID_WIDTH-1:0]    wb_id;

  // scoreboard, filled at acceptance and drained at retirement
  fp_mul_pkg::fp_mul_wb_t exp_wb_q[$];
  logic [ID_WIDTH-1:0]    exp_id_q[$];
  fp_mul_pkg::fp_mul_wb_t exp_wb;
  logic [ID_WIDTH-1:0]    exp_id;
  logic                   exp_ready;
  logic [ID_WIDTH-1:0]    next_id     = '0;

  integer      seed        = SEED;
  integer      ack_seed    = ~SEED;
  int          ack_mode    = 0;
  int          stretch     = 0;
  int          cycles      = 0;
  int          stall_count = 0;
  logic [31:0] ack_rnd;

  fp_mul_unit #(.ID_WIDTH(ID_WIDTH)) u_fp_mul_unit (
    .clk         (clk),
    .rst_n       (rst_n),
    .new_request (new_request),
    .req         (req),
    .id          (id),
    .ready       (ready),
    .done        (done),
    .wb          (wb),
    .wb_id       (wb_id),
    .ack         (ack)
  );

  always #2 clk = ~clk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model, binary32 multiply with flush to zero

  function automatic fp_mul_pkg::fp_mul_wb_t mul_model(input logic [31:0] a,
                                                       input logic [31:0] b,
                                                       input logic [2:0]  rm);
    fp_mul_pkg::fp_mul_wb_t r;
    logic [7:0]  ea;
    logic [7:0]  eb;
    logic [22:0] fa;
    logic [22:0] fb;
    logic        sgn, za, zb, ia, ib, na, nb, inv, grd, stk, inc, ovf_inf;
    logic [47:0] p;
    logic [24:0] m;
    int          e;
    ea = a[30:23];
    eb = b[30:23];
    fa = a[22:0];
    fb = b[22:0];
    r.fflags = 5'b00000;
    sgn = a[31] ^ b[31];
    za = (ea == 8'h00);
    zb = (eb == 8'h00);
    ia = (ea == 8'hff) && (fa == '0);
    ib = (eb == 8'hff) && (fb == '0);
    na = (ea == 8'hff) && (fa != '0);
    nb = (eb == 8'hff) && (fb != '0);
    inv = (na && !fa[22]) || (nb && !fb[22]) || (ia && zb) || (za && ib);
    if (inv || na || nb) begin
      r.rd = 32'h7fc00000;
      r.fflags[4] = inv;
      return r;
    end
    if (ia || ib) begin
      r.rd = {sgn, 8'hff, 23'd0};
      return r;
    end
    if (za || zb) begin
      r.rd = {sgn, 31'd0};
      return r;
    end
    p = 48'({1'b1, fa}) * 48'({1'b1, fb});
    e = int'(ea) + int'(eb) - 127;
    // product lies in [1,4), keep 24 bits below the leading one
    if (p[47]) begin
      m = {1'b0, p[47:24]};
      grd = p[23];
      stk = |p[22:0];
      e++;
    end else begin
      m = {1'b0, p[46:23]};
      grd = p[22];
      stk = |p[21:0];
    end
    if (e <= 0) begin
      r.rd = {sgn, 31'd0};
      r.fflags = 5'b00011;
      return r;
    end
    case (rm)
      3'd0:    inc = grd && (stk || m[0]);
      3'd2:    inc = sgn && (grd || stk);
      3'd3:    inc = !sgn && (grd || stk);
      3'd4:    inc = grd;
      default: inc = 1'b0;
    endcase
    m = m + 25'(inc);
    if (m[24]) begin
      e++;
      m = m >> 1;
    end
    if (e >= 255) begin
      case (rm)
        3'd1:    ovf_inf = 1'b0;
        3'd2:    ovf_inf = sgn;
        3'd3:    ovf_inf = !sgn;
        default: ovf_inf = 1'b1;
      endcase
      r.rd = ovf_inf ? {sgn, 8'hff, 23'd0} : {sgn, 8'hfe, 23'h7fffff};
      r.fflags = 5'b00101;
      return r;
    end
    r.rd = {sgn, e[7:0], m[22:0]};
    r.fflags[0] = grd || stk;
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers

  // holds the request until it is accepted
  task automatic issue_op(input logic [31:0] a, input logic [31:0] b,
                          input logic [2:0] rm);
    @(negedge clk);
    new_request = 1'b1;
    req.rs1 = a;
    req.rs2 = b;
    req.rm = fp_mul_pkg::rounding_mode_t'(rm);
    id = next_id;
    @(posedge clk);
    while (!ready) @(posedge clk);
    next_id = next_id + ID_WIDTH'(1);
  endtask

  task automatic drain_pipeline();
    int k;
    k = 0;
    @(negedge clk);
    new_request = 1'b0;
    while (exp_wb_q.size() != 0 && k < 200) begin
      @(posedge clk);
      k++;
    end
    assert (exp_wb_q.size() == 0) else fail_run("results were lost in the pipeline");
  endtask

  // ack policy: 0 held high, 1 random per cycle, 2 random stretches
  always @(negedge clk) begin
    case (ack_mode)
      1: begin
        ack_rnd = $random(ack_seed);
        ack = ack_rnd[0];
      end
      2: begin
        if (stretch == 0) begin
          ack_rnd = $random(ack_seed);
          ack = ~ack;
          stretch = int'(ack_rnd[2:0]) + 1;
        end else begin
          stretch--;
        end
      end
      default: ack = 1'b1;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // monitor and scoreboard

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) fail_run("the run did not finish within the cycle limit");
    if (rst_n) begin
      if (!ready) stall_count++;
      // three in flight with the output stalled, nothing more fits
      exp_ready = !(exp_wb_q.size() == 3 && !ack);
      assert (ready == exp_ready)
        else fail_run($sformatf("ERR ready expected %h got %h", exp_ready, ready));
      if (done && ack) begin
        assert (exp_wb_q.size() != 0)
          else fail_run("a result retired with no request outstanding");
        exp_wb = exp_wb_q.pop_front();
        exp_id = exp_id_q.pop_front();
        assert (wb.rd == exp_wb.rd)
          else fail_run($sformatf("ERR wb.rd expected %h got %h", exp_wb.rd, wb.rd));
        assert (wb.fflags == exp_wb.fflags)
          else fail_run($sformatf("ERR wb.fflags expected %h got %h",
                                  exp_wb.fflags, wb.fflags));
        assert (wb_id == exp_id)
          else fail_run($sformatf("ERR wb_id expected %h got %h", exp_id, wb_id));
      end
      if (new_request && ready) begin
        exp_wb_q.push_back(mul_model(req.rs1, req.rs2, req.rm));
        exp_id_q.push_back(id);
      end
    end
  end

  initial begin
    int                     n;
    logic [31:0]            ra, rb, rr;
    fp_mul_pkg::fp_mul_wb_t chk;
    logic [31:0]            round_a [3] = '{32'h3f800001, 32'h3fffffff, 32'hbf8ccccd};
    logic [31:0]            round_b [3] = '{32'h3f800003, 32'hbfffffff, 32'h40490fdb};
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // idle state and single-op latency, 1.5 * 2.0 = 3.0
    assert (!done && ready) else fail_run("done or ready has the wrong value after reset");
    chk = mul_model(32'h3fc00000, 32'h40000000, 3'd0);
    assert (chk == {32'h40400000, 5'b00000})
      else fail_run("reference model gives the wrong product of 1.5 and 2.0");
    issue_op(32'h3fc00000, 32'h40000000, 3'd0);
    @(negedge clk);
    new_request = 1'b0;
    n = 1;
    while (!done) begin
      @(negedge clk);
      n++;
    end
    assert (n == 3) else fail_run($sformatf("result took %0d cycles instead of 3", n));
    drain_pipeline();

    // specials
    issue_op(32'h7f800000, 32'h00000000, 3'd0);
    issue_op(32'h7f800001, 32'h3f800000, 3'd0);
    issue_op(32'h7fc00001, 32'h40000000, 3'd0);
    issue_op(32'h7f800000, 32'hc0000000, 3'd0);
    issue_op(32'h80000000, 32'h3f800000, 3'd0);
    issue_op(32'h00400000, 32'hbf800000, 3'd0);
    drain_pipeline();

    // rounding in every mode on inexact products
    for (int rm = 0; rm < 5; rm++) begin
      for (int k = 0; k < 3; k++) begin
        chk = mul_model(round_a[k], round_b[k], 3'(rm));
        assert (chk.fflags[0]) else fail_run("rounding operands gave an exact product");
        issue_op(round_a[k], round_b[k], 3'(rm));
      end
    end
    drain_pipeline();

    // overflow of both signs, then underflow
    for (int rm = 0; rm < 5; rm++) begin
      issue_op(32'h7f000000, 32'h40000000, 3'(rm));
      issue_op(32'h7f000000, 32'hc0000000, 3'(rm));
      issue_op(32'h7f7fffff, 32'h7f7fffff, 3'(rm));
      issue_op(32'h1f800000, 32'h9f800000, 3'(rm));
      issue_op(32'h00800000, 32'h00800000, 3'(rm));
    end
    drain_pipeline();

    // back-pressure with ack low for random stretches
    ack_mode = 2;
    n = stall_count;
    repeat (NUM_BACKPRESSURE) begin
      ra = $random(seed);
      rb = $random(seed);
      rr = $random(seed);
      issue_op(ra, rb, 3'(rr % 32'd5));
    end
    assert (stall_count > n) else fail_run("ready never dropped while ack was held low");
    drain_pipeline();

    // random throughput run
    ack_mode = 1;
    repeat (NUM_RANDOM) begin
      ra = $random(seed);
      rb = $random(seed);
      rr = $random(seed);
      issue_op(ra, rb, 3'(rr % 32'd5));
    end
    drain_pipeline();

    if (exp_wb_q.size() == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      fail_run("results still outstanding at the end of the run");
    end
  end

endmodule

`default_nettype wire

//--- project.f
hw/fp_mul_pkg.sv
hw/fp_operand_classify.sv
hw/fp_mant_multiplier.sv
hw/fp_exponent_path.sv
hw/fp_mul_normalize_round.sv
hw/fp_mul_pipeline_ctrl.sv
hw/fp_mul_unit.sv
testbench/fp_mul_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module fp_mul_tb -f project.f -o fp_mul_sim

out=$(./obj_dir/fp_mul_sim 2>&1 || true)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "SIMULATION PASSED"
